// ==== rtl/merge_sort_config.svh ====
`ifndef MERGE_SORT_CONFIG_SVH
`define MERGE_SORT_CONFIG_SVH

// Block geometry
`define MS_NUM_RECORDS 8
`define MS_COLUMNS     3
`define MS_BYTE_W      8

// FIFO depths between tree levels
// First level holds one sorted pair
`define MS_PAIR_DEPTH  2
// Second level holds one run of four
`define MS_RUN4_DEPTH  4

`endif

// ==== rtl/merge_sort_pkg.sv ====
`default_nettype none

`include "merge_sort_config.svh"

package merge_sort_pkg;

    // One column of a record
    typedef logic [`MS_BYTE_W-1:0] byte_t;

    // Column 0 sits in the low byte
    typedef byte_t [`MS_COLUMNS-1:0] record_t;

    // Record 0 sits in the low bits
    typedef record_t [`MS_NUM_RECORDS-1:0] block_t;

    // Sort key of a record from column 0 or column 1
    function automatic byte_t key_of(input record_t rec, input logic key_sel);
        byte_t key;
        if (key_sel) begin
            key = rec[1];
        end else begin
            key = rec[0];
        end
        return key;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/record_stream_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Valid/ready record stream between tree stages
interface record_stream_if
    import merge_sort_pkg::*;
#(
    parameter type T = record_t
) ();

    logic valid;
    T     data;
    // Final record of a run
    logic last;
    logic ready;

    // Producer side
    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// ==== rtl/pair_sorter.sv ====
`timescale 1ns/10ps
`default_nettype none

module pair_sorter
    import merge_sort_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic            key_sel,
    input  record_t         rec_a,
    input  record_t         rec_b,
    record_stream_if.source out
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_LO,
        SEND_HI
    } state_t;

    state_t  state;
    record_t lo_q;
    record_t hi_q;
    logic    swap;

    // rec_b leads only on a strictly smaller key
    assign swap = key_of(rec_b, key_sel) < key_of(rec_a, key_sel);

    // Ordered pair captured on load
    always_ff @(posedge clk) begin
        if (load) begin
            lo_q <= swap ? rec_b : rec_a;
            hi_q <= swap ? rec_a : rec_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (load) begin
            state <= SEND_LO;
        end else begin
            case (state)
                SEND_LO: if (out.ready) state <= SEND_HI;
                SEND_HI: if (out.ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Two-record run with last on the larger one
    assign out.valid = (state != IDLE);
    assign out.data  = (state == SEND_HI) ? hi_q : lo_q;
    assign out.last  = (state == SEND_HI);

endmodule

`default_nettype wire

// ==== rtl/run_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module run_fifo
    import merge_sort_pkg::*;
#(
    parameter type T     = record_t,
    parameter int  DEPTH = 2
) (
    input  logic            clk,
    input  logic            rst,
    record_stream_if.sink   in,
    record_stream_if.source out
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem      [DEPTH];
    logic          last_mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    // Wrap for depths that are not a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        logic [PW-1:0] nxt;
        if (ptr == PW'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PW'(1);
        end
        return nxt;
    endfunction

    assign in.ready  = (count != CW'(DEPTH));
    assign out.valid = (count != '0);
    assign out.data  = mem[rd_ptr];
    assign out.last  = last_mem[rd_ptr];

    assign do_wr = in.valid && in.ready;
    assign do_rd = out.valid && out.ready;

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr]      <= in.data;
            last_mem[wr_ptr] <= in.last;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/run_merger.sv ====
`timescale 1ns/10ps
`default_nettype none

module run_merger
    import merge_sort_pkg::*;
#(
    parameter int RUN_LEN = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            key_sel,
    record_stream_if.sink   left,
    record_stream_if.sink   right,
    record_stream_if.source out
);

    localparam int            CW       = $clog2(2 * RUN_LEN + 1);
    localparam logic [CW-1:0] LEN      = CW'(RUN_LEN);
    localparam logic [CW-1:0] LAST_IDX = CW'(2 * RUN_LEN - 1);

    logic [CW-1:0] cnt_l;
    logic [CW-1:0] cnt_r;
    logic          l_more;
    logic          r_more;
    logic          adv;
    logic          take_l;
    logic          take_r;
    logic          final_rec;

    logic          out_vld_q;
    logic          out_last_q;
    record_t       out_data_q;

    assign l_more = (cnt_l != LEN);
    assign r_more = (cnt_r != LEN);

    // Output register is free or empties this cycle
    assign adv = !out_vld_q || out.ready;

    // Left head wins ties for stability
    always_comb begin
        take_l = 1'b0;
        take_r = 1'b0;
        if (adv) begin
            if (l_more && r_more) begin
                if (left.valid && right.valid) begin
                    if (key_of(right.data, key_sel) < key_of(left.data, key_sel)) begin
                        take_r = 1'b1;
                    end else begin
                        take_l = 1'b1;
                    end
                end
            end else if (l_more) begin
                // Right side spent
                take_l = left.valid;
            end else if (r_more) begin
                take_r = right.valid;
            end
        end
    end

    assign left.ready  = take_l;
    assign right.ready = take_r;

    assign final_rec = (cnt_l + cnt_r) == LAST_IDX;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_vld_q  <= 1'b0;
            out_last_q <= 1'b0;
            cnt_l      <= '0;
            cnt_r      <= '0;
        end else if (take_l || take_r) begin
            out_vld_q  <= 1'b1;
            out_last_q <= final_rec;
            if (final_rec) begin
                // Ready for the next pair of runs
                cnt_l <= '0;
                cnt_r <= '0;
            end else if (take_l) begin
                cnt_l <= cnt_l + CW'(1);
            end else begin
                cnt_r <= cnt_r + CW'(1);
            end
        end else if (out.ready) begin
            out_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_l) begin
            out_data_q <= left.data;
        end else if (take_r) begin
            out_data_q <= right.data;
        end
    end

    assign out.valid = out_vld_q;
    assign out.data  = out_data_q;
    assign out.last  = out_last_q;

endmodule

`default_nettype wire

// ==== rtl/merge_sort_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "merge_sort_config.svh"

module merge_sort_top
    import merge_sort_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   key_sel,
    input  block_t data_in,
    output block_t data_out,
    output logic   busy,
    output logic   sorted
);

    localparam int NUM_PAIRS = `MS_NUM_RECORDS / 2;
    localparam int NUM_RUN4  = `MS_NUM_RECORDS / 4;
    localparam int IDX_W     = $clog2(`MS_NUM_RECORDS);

    logic             accept;
    logic             key_q;
    logic [IDX_W-1:0] idx;

    // Sorter to FIFO and FIFO to merger on each level
    record_stream_if #(.T(record_t)) pair_s [NUM_PAIRS] ();
    record_stream_if #(.T(record_t)) pair_f [NUM_PAIRS] ();
    record_stream_if #(.T(record_t)) run4_s [NUM_RUN4] ();
    record_stream_if #(.T(record_t)) run4_f [NUM_RUN4] ();
    record_stream_if #(.T(record_t)) final_s ();

    // A start during a sort is ignored
    assign accept = start && !busy;

    //////////////////////////////////////////////////
    // First level of sorted pairs
    //////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_PAIRS; g++) begin : g_pair
        // Raw key select is sampled on the accept edge
        pair_sorter u_sorter (
            .clk     (clk),
            .rst     (rst),
            .load    (accept),
            .key_sel (key_sel),
            .rec_a   (data_in[2*g]),
            .rec_b   (data_in[2*g+1]),
            .out     (pair_s[g])
        );

        run_fifo #(.T(record_t), .DEPTH(`MS_PAIR_DEPTH)) u_fifo (
            .clk (clk),
            .rst (rst),
            .in  (pair_s[g]),
            .out (pair_f[g])
        );
    end

    //////////////////////////////////////////////////
    // Second level with runs of four
    //////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_RUN4; g++) begin : g_run4
        run_merger #(.RUN_LEN(2)) u_merger (
            .clk     (clk),
            .rst     (rst),
            .key_sel (key_q),
            .left    (pair_f[2*g]),
            .right   (pair_f[2*g+1]),
            .out     (run4_s[g])
        );

        run_fifo #(.T(record_t), .DEPTH(`MS_RUN4_DEPTH)) u_fifo (
            .clk (clk),
            .rst (rst),
            .in  (run4_s[g]),
            .out (run4_f[g])
        );
    end

    //////////////////////////////////////////////////
    // Third level merging the full block
    //////////////////////////////////////////////////

    run_merger #(.RUN_LEN(4)) u_final_merger (
        .clk     (clk),
        .rst     (rst),
        .key_sel (key_q),
        .left    (run4_f[0]),
        .right   (run4_f[1]),
        .out     (final_s)
    );

    //////////////////////////////////////////////////
    // Collector
    //////////////////////////////////////////////////

    // No back-pressure at the top
    assign final_s.ready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            sorted <= 1'b0;
            key_q  <= 1'b0;
            idx    <= '0;
        end else if (accept) begin
            busy   <= 1'b1;
            sorted <= 1'b0;
            key_q  <= key_sel;
            idx    <= '0;
        end else if (busy && final_s.valid) begin
            idx <= idx + IDX_W'(1);
            // Eighth record closes the sort
            if (final_s.last) begin
                busy   <= 1'b0;
                sorted <= 1'b1;
            end
        end
    end

    // Output block only moves during a sort
    always_ff @(posedge clk) begin
        if (busy && final_s.valid) begin
            data_out[idx] <= final_s.data;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/merge_sort_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "merge_sort_config.svh"

module merge_sort_tb
    import merge_sort_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    // Sort runs over all tests for the watchdog
    localparam int NUM_RUNS     = 38;
    localparam int SORT_TIMEOUT = 100;

    logic   clk = 1'b0;
    logic   rst;
    logic   start;
    logic   key_sel;
    block_t data_in;
    block_t data_out;
    logic   busy;
    logic   sorted;

    merge_sort_top merge_sort_top_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .key_sel  (key_sel),
        .data_in  (data_in),
        .data_out (data_out),
        .busy     (busy),
        .sorted   (sorted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NUM_RUNS * 200 * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $fatal(1, "Simulation timeout");
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Column 0 is the low byte and column 1 the next one up
    function automatic byte_t sort_key(input record_t rec, input logic sel);
        logic [$bits(record_t)-1:0] bits;
        bits = rec;
        return bits[{sel, 3'b000} +: `MS_BYTE_W];
    endfunction

    // Stable insertion sort that moves only on a strictly larger key
    function automatic block_t model_sort(input block_t blk, input logic sel);
        block_t  res;
        record_t tmp;
        int      j;
        res = blk;
        for (int i = 1; i < `MS_NUM_RECORDS; i++) begin
            j = i;
            while (j > 0 && sort_key(res[j-1], sel) > sort_key(res[j], sel)) begin
                tmp = res[j];
                res[j] = res[j-1];
                res[j-1] = tmp;
                j--;
            end
        end
        return res;
    endfunction

    function automatic block_t random_block();
        block_t blk;
        for (int i = 0; i < `MS_NUM_RECORDS; i++) begin
            for (int c = 0; c < `MS_COLUMNS; c++) begin
                blk[i][c] = byte_t'($urandom);
            end
        end
        return blk;
    endfunction

    //////////////////////////////////////////////////
    // Drive and check helpers
    //////////////////////////////////////////////////

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic start_sort(input block_t blk, input logic sel);
        @(posedge clk);
        data_in <= blk;
        key_sel <= sel;
        start   <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        // Busy rises and sorted falls on the accept edge
        @(negedge clk);
        assert (busy && !sorted) else flag_error("busy or sorted wrong after start");
    endtask

    // Optionally pokes start with another block while the sort runs
    task automatic wait_sorted(input logic poke, input block_t other, output int cycles);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < SORT_TIMEOUT) begin
            @(posedge clk);
            if (poke && n == 2) begin
                start   <= 1'b1;
                data_in <= other;
                key_sel <= !key_sel;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            n++;
            if (sorted) begin
                done = 1'b1;
            end else begin
                assert (busy) else flag_error("busy low before sorted");
            end
        end
        assert (done) else flag_error("sorted never rose, sort timed out");
        assert (!busy) else flag_error("busy still high after sorted");
        cycles = n;
    endtask

    task automatic run_and_check(input block_t blk, input logic sel, input logic poke,
                                 input block_t other, input string label,
                                 output int cycles);
        block_t expected;
        expected = model_sort(blk, sel);
        start_sort(blk, sel);
        wait_sorted(poke, other, cycles);
        assert (data_out === expected)
            else flag_error($sformatf("%s: got %h expected %h", label, data_out, expected));
    endtask

    // Equal keys must keep ascending input index in column 2
    task automatic check_stable(input logic sel);
        for (int i = 1; i < `MS_NUM_RECORDS; i++) begin
            if (sort_key(data_out[i], sel) == sort_key(data_out[i-1], sel)) begin
                assert (data_out[i][2] > data_out[i-1][2])
                    else flag_error($sformatf("order of equal keys lost at %0d", i));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_random(input logic sel, input int blocks);
        int cycles;
        for (int b = 0; b < blocks; b++) begin
            run_and_check(random_block(), sel, 1'b0, '0, "random block", cycles);
        end
    endtask

    task automatic test_stability();
        block_t blk;
        int     cycles;
        for (int i = 0; i < `MS_NUM_RECORDS; i++) begin
            blk[i][0] = 8'h5a;
            blk[i][1] = 8'h5a;
            blk[i][2] = byte_t'(i);
        end
        run_and_check(blk, 1'b0, 1'b0, '0, "all keys equal", cycles);
        check_stable(1'b0);
        // Two key values interleaved
        for (int i = 0; i < `MS_NUM_RECORDS; i++) begin
            blk[i][1] = (i % 3 == 0) ? 8'h40 : 8'h20;
        end
        run_and_check(blk, 1'b1, 1'b0, '0, "two key values", cycles);
        check_stable(1'b1);
    endtask

    task automatic test_ordered_and_timing();
        block_t up;
        block_t down;
        block_t blk;
        int     cycles;
        int     ref_cycles;
        for (int i = 0; i < `MS_NUM_RECORDS; i++) begin
            up[i]   = {byte_t'(i), byte_t'(8'h80 - i), byte_t'(i * 16 + 3)};
            down[i] = {byte_t'(i), byte_t'(i * 9), byte_t'(8'hf0 - i * 16)};
        end
        run_and_check(up, 1'b0, 1'b0, '0, "ascending block", cycles);
        run_and_check(down, 1'b0, 1'b0, '0, "descending block", cycles);
        run_and_check(up, 1'b1, 1'b0, '0, "ascending on column 1", cycles);
        // Same block twice with a start during the second sort
        blk = random_block();
        run_and_check(blk, 1'b0, 1'b0, '0, "latency reference", ref_cycles);
        run_and_check(blk, 1'b0, 1'b1, down, "start while busy", cycles);
        assert (cycles == ref_cycles)
            else flag_error($sformatf("start while busy moved sorted: %0d vs %0d cycles",
                                      cycles, ref_cycles));
    endtask

    task automatic test_reset_abort();
        int cycles;
        start_sort(random_block(), 1'b1);
        repeat (5) @(posedge clk);
        assert (busy) else flag_error("busy low before the reset in mid-sort");
        rst <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        assert (!busy && !sorted) else flag_error("busy or sorted high during reset");
        @(posedge clk);
        rst <= 1'b0;
        run_and_check(random_block(), 1'b0, 1'b0, '0, "sort after reset", cycles);
    endtask

    initial begin
        rst     = 1'b1;
        start   = 1'b0;
        key_sel = 1'b0;
        data_in = '0;
        void'($urandom(14750));
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_random(1'b0, 20);
        test_random(1'b1, 10);
        test_stability();
        test_ordered_and_timing();
        test_reset_abort();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/merge_sort_pkg.sv
rtl/record_stream_if.sv
rtl/pair_sorter.sv
rtl/run_fifo.sv
rtl/run_merger.sv
rtl/merge_sort_top.sv
testbench/merge_sort_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the merge sort testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module merge_sort_tb \
    -o merge_sort_sim

./obj_dir/merge_sort_sim
